//--- verilog/zx_pkg.sv
// Spectrum paging core shared types, machine codes and port constants
`default_nettype none

package zx_pkg;

	// ==============================
	// Bus and memory widths
	// ==============================

	// Z80 address bus and data byte
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	// 2 MB byte-wide RAM
	typedef logic [20:0] ram_addr_t;

	// 16 KB page numbers
	typedef logic [5:0]  ram_page_t;
	typedef logic [3:0]  rom_page_t;

	// ROM pages live at RAM page 80 and up
	localparam logic [2:0] ROM_PAGE_BASE = 3'b101;

	// ==============================
	// Machine selection
	// ==============================

	typedef logic [2:0] machine_t;

	localparam machine_t MACHINE_128K  = 3'd0;
	localparam machine_t MACHINE_P1024 = 3'd1;
	localparam machine_t MACHINE_PROFI = 3'd2;
	localparam machine_t MACHINE_48K   = 3'd3;
	localparam machine_t MACHINE_PLUS3 = 3'd4;

	// Profi extension port, fully decoded
	localparam cpu_addr_t PROFI_PORT = 16'hDFFD;

	// ==============================
	// Joysticks
	// ==============================

	typedef logic [2:0] joy_mode_t;

	localparam joy_mode_t JOY_KEMPSTON   = 3'd0;
	localparam joy_mode_t JOY_SINCLAIR1  = 3'd1;
	localparam joy_mode_t JOY_SINCLAIR2  = 3'd2;
	localparam joy_mode_t JOY_SINCLAIR12 = 3'd3;
	localparam joy_mode_t JOY_CURSOR     = 3'd4;

	// Bit 0 right, 1 left, 2 down, 3 up, 4 fire1, 5 fire2
	typedef logic [5:0] joy_t;

endpackage

`default_nettype wire

//--- verilog/bus_cycle_decode.sv
// I/O write decoder producing registered one-cycle port-write pulses
`timescale 1ns/10ps
`default_nettype none

module bus_cycle_decode (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::cpu_addr_t addr,
	input  zx_pkg::byte_t     cpu_dout,
	input  logic              iorq_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic              plus3,
	output logic              wr_7ffd,
	output logic              wr_1ffd,
	output logic              wr_eff7,
	output logic              wr_dffd,
	output logic              wr_ula,
	output zx_pkg::byte_t     wr_data
);

	import zx_pkg::*;

	logic io_wr;
	logic io_wr_q;
	logic io_wr_start;

	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_eff7;
	logic hit_dffd;
	logic hit_ula;

	// Interrupt acknowledge also drives iorq_n low, so m1_n must be high
	assign io_wr       = ~iorq_n & ~wr_n & m1_n;
	assign io_wr_start = io_wr & ~io_wr_q;

	// ==============================
	// Partial port decoding
	// ==============================

	// On +3 the 7FFD decode also needs A14 so 1FFD can sit below it
	assign hit_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~plus3);
	assign hit_1ffd = ~addr[15] & ~addr[14] & ~addr[13] & addr[12] & ~addr[1];
	assign hit_eff7 = addr[15] & addr[14] & addr[13] & ~addr[12] & ~addr[3];
	assign hit_dffd = (addr == PROFI_PORT);
	assign hit_ula  = ~addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			wr_7ffd <= 1'b0;
			wr_1ffd <= 1'b0;
			wr_eff7 <= 1'b0;
			wr_dffd <= 1'b0;
			wr_ula  <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			wr_7ffd <= io_wr_start & hit_7ffd;
			wr_1ffd <= io_wr_start & hit_1ffd;
			wr_eff7 <= io_wr_start & hit_eff7;
			wr_dffd <= io_wr_start & hit_dffd;
			wr_ula  <= io_wr_start & hit_ula;
		end
	end

	// Data byte follows the pulse
	always_ff @(posedge clk_sys) begin
		if (io_wr_start) begin
			wr_data <= cpu_dout;
		end
	end

endmodule

`default_nettype wire

//--- verilog/page_registers.sv
// Machine latch, 7FFD/1FFD/EFF7/DFFD paging registers and page lock
`timescale 1ns/10ps
`default_nettype none

module page_registers (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::machine_t  machine,
	input  logic              wr_7ffd,
	input  logic              wr_1ffd,
	input  logic              wr_eff7,
	input  logic              wr_dffd,
	input  zx_pkg::byte_t     wr_data,
	output zx_pkg::ram_page_t page_ram,
	output zx_pkg::rom_page_t page_rom,
	output logic              special_mode,
	output logic [1:0]        special_sel,
	output logic              plus3
);

	import zx_pkg::*;

	machine_t machine_q;

	logic is_48k;
	logic is_p1024;
	logic is_profi;

	// 7FFD fields in use: RAM bank, ROM select, lock
	logic [2:0] bank_7ffd;
	logic       rom_7ffd;
	logic       lock_7ffd;

	// 1FFD bits 2 to 0
	logic [2:0] reg_1ffd;

	// EFF7 bit 2 turns the Pentagon 7FFD extension off
	logic       ext_off_eff7;

	// Upper RAM page bits from Pentagon 7FFD or Profi DFFD
	logic [2:0] page_ext;

	logic page_lock;

	assign is_48k   = (machine_q == MACHINE_48K);
	assign is_p1024 = (machine_q == MACHINE_P1024);
	assign is_profi = (machine_q == MACHINE_PROFI);
	assign plus3    = (machine_q == MACHINE_PLUS3);

	// ==============================
	// Page lock
	// ==============================

	assign page_lock = is_48k
		| (~is_p1024 & lock_7ffd)
		| (is_p1024 & ext_off_eff7 & lock_7ffd);

	// ==============================
	// Register updates
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Mode is sampled only while reset is held
			machine_q    <= machine;
			bank_7ffd    <= 3'd0;
			rom_7ffd     <= 1'b0;
			lock_7ffd    <= 1'b0;
			reg_1ffd     <= 3'd0;
			ext_off_eff7 <= 1'b0;
			page_ext     <= 3'd0;
		end else begin
			if (wr_7ffd && !page_lock) begin
				bank_7ffd <= wr_data[2:0];
				rom_7ffd  <= wr_data[4];
				lock_7ffd <= wr_data[5];
				// Pentagon 1024 takes bits 5, 7, 6 as the page extension
				if (is_p1024 && !ext_off_eff7) begin
					page_ext <= {wr_data[5], wr_data[7:6]};
				end
			end else if (wr_1ffd && !page_lock && plus3) begin
				reg_1ffd <= wr_data[2:0];
			end

			if (wr_eff7 && is_p1024) begin
				ext_off_eff7 <= wr_data[2];
			end

			if (wr_dffd && is_profi) begin
				page_ext <= wr_data[2:0];
			end
		end
	end

	// ==============================
	// Page outputs
	// ==============================

	assign page_ram = {page_ext, bank_7ffd};

	always_comb begin
		if (is_48k) begin
			page_rom = 4'b1111;
		end else if (plus3) begin
			page_rom = {2'b10, reg_1ffd[2], rom_7ffd};
		end else begin
			page_rom = {3'b011, rom_7ffd};
		end
	end

	assign special_mode = reg_1ffd[0];
	assign special_sel  = reg_1ffd[2:1];

endmodule

`default_nettype wire

//--- verilog/memory_map.sv
// CPU address to RAM address translation and RAM strobes
`timescale 1ns/10ps
`default_nettype none

module memory_map (
	input  logic              mreq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  zx_pkg::cpu_addr_t addr,
	input  zx_pkg::ram_page_t page_ram,
	input  zx_pkg::rom_page_t page_rom,
	input  logic              special_mode,
	input  logic [1:0]        special_sel,
	output zx_pkg::ram_addr_t ram_addr,
	output logic              ram_we,
	output logic              ram_rd
);

	import zx_pkg::*;

	logic [1:0] slot;
	ram_page_t  special_page;
	ram_page_t  normal_page;

	// 16 KB slot of the Z80 address space
	assign slot = addr[15:14];

	// ==============================
	// +3 all-RAM layouts
	// ==============================

	always_comb begin
		case (special_sel)
			2'd0: special_page = {4'd0, slot};
			2'd1: special_page = {4'd1, slot};
			2'd2: special_page = (slot == 2'd3) ? 6'd3 : {4'd1, slot};
			default: begin
				// Layout 4, 7, 6, 3
				case (slot)
					2'd0: special_page = 6'd4;
					2'd1: special_page = 6'd7;
					2'd2: special_page = 6'd6;
					default: special_page = 6'd3;
				endcase
			end
		endcase
	end

	// Fixed pages 5 and 2 in the middle slots
	always_comb begin
		case (slot)
			2'd1: normal_page = 6'd5;
			2'd2: normal_page = 6'd2;
			default: normal_page = page_ram;
		endcase
	end

	always_comb begin
		if (special_mode) begin
			ram_addr = {1'b0, special_page, addr[13:0]};
		end else if (slot == 2'd0) begin
			ram_addr = {ROM_PAGE_BASE, page_rom, addr[13:0]};
		end else begin
			ram_addr = {1'b0, normal_page, addr[13:0]};
		end
	end

	// ==============================
	// Strobes
	// ==============================

	assign ram_rd = ~mreq_n & ~rd_n;

	// ROM slot is write protected unless all-RAM mode is on
	assign ram_we = ~mreq_n & ~wr_n & (special_mode | (slot != 2'd0));

endmodule

`default_nettype wire

//--- verilog/io_ports.sv
// ULA output latch, joystick key mapping and I/O read-back multiplexer
`timescale 1ns/10ps
`default_nettype none

module io_ports (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::cpu_addr_t addr,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              m1_n,
	input  logic              wr_ula,
	input  zx_pkg::byte_t     wr_data,
	input  zx_pkg::joy_mode_t joy_mode,
	input  zx_pkg::joy_t      joy_0,
	input  zx_pkg::joy_t      joy_1,
	input  logic [4:0]        key_data,
	input  logic              tape_in,
	output zx_pkg::byte_t     cpu_din,
	output logic [2:0]        border,
	output logic              ear_out,
	output logic              mic_out
);

	import zx_pkg::*;

	// Keys 6 to 0 as bits 4 to 0: left, right, down, up, fire
	function automatic logic [4:0] sinclair1_keys(input joy_t j);
		return {j[1], j[0], j[2], j[3], j[4]};
	endfunction

	// Keys 5 to 1 as bits 4 to 0: fire, up, down, right, left
	function automatic logic [4:0] sinclair2_keys(input joy_t j);
		return {j[4], j[3], j[2], j[0], j[1]};
	endfunction

	// Cursor on the 6-0 row: down, up, right, unused, fire
	function automatic logic [4:0] cursor_keys(input joy_t j);
		return {j[2], j[3], j[0], 1'b0, j[4]};
	endfunction

	logic       io_rd;
	byte_t      kempston_byte;
	logic [4:0] keys_row_a12;
	logic [4:0] keys_row_a11;
	logic [4:0] joy_mask;

	// ==============================
	// ULA output latch
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (wr_ula) begin
			border  <= wr_data[2:0];
			ear_out <= wr_data[4];
			mic_out <= wr_data[3];
		end
	end

	// ==============================
	// Joystick mapping
	// ==============================

	assign kempston_byte = (joy_mode == JOY_KEMPSTON) ? {2'b00, joy_0 | joy_1} : 8'h00;

	always_comb begin
		keys_row_a12 = 5'd0;
		keys_row_a11 = 5'd0;
		// Sinclair I+II splits the two sticks across both rows
		if (joy_mode == JOY_SINCLAIR1 || joy_mode == JOY_SINCLAIR12) begin
			keys_row_a12 = keys_row_a12 | sinclair1_keys(joy_0);
		end
		if (joy_mode == JOY_SINCLAIR1) begin
			keys_row_a12 = keys_row_a12 | sinclair1_keys(joy_1);
		end
		if (joy_mode == JOY_SINCLAIR2 || joy_mode == JOY_SINCLAIR12) begin
			keys_row_a11 = keys_row_a11 | sinclair2_keys(joy_1);
		end
		if (joy_mode == JOY_SINCLAIR2) begin
			keys_row_a11 = keys_row_a11 | sinclair2_keys(joy_0);
		end
		if (joy_mode == JOY_CURSOR) begin
			keys_row_a12 = cursor_keys(joy_0) | cursor_keys(joy_1);
			// Left is key 5, on the other half row
			keys_row_a11 = {joy_0[1] | joy_1[1], 4'b0000};
		end
	end

	// Active-low key mask, only for the half rows being scanned
	assign joy_mask = ({5{addr[12]}} | ~keys_row_a12) & ({5{addr[11]}} | ~keys_row_a11);

	// ==============================
	// Read-back multiplexer
	// ==============================

	assign io_rd = ~iorq_n & ~rd_n & m1_n;

	always_comb begin
		cpu_din = 8'hFF;
		if (io_rd) begin
			if (addr[7:0] == 8'h1F) begin
				cpu_din = kempston_byte;
			end else if (!addr[0]) begin
				cpu_din = {1'b1, ~tape_in, 1'b1, key_data & joy_mask};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/zx_memory_io.sv
// Spectrum memory paging and I/O port core between the Z80 bus and RAM
`timescale 1ns/10ps
`default_nettype none

module zx_memory_io (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::cpu_addr_t addr,
	input  zx_pkg::byte_t     cpu_dout,
	input  logic              mreq_n,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  zx_pkg::machine_t  machine,
	input  zx_pkg::joy_mode_t joy_mode,
	input  zx_pkg::joy_t      joy_0,
	input  zx_pkg::joy_t      joy_1,
	input  logic [4:0]        key_data,
	input  logic              tape_in,
	output zx_pkg::ram_addr_t ram_addr,
	output logic              ram_we,
	output logic              ram_rd,
	output zx_pkg::byte_t     cpu_din,
	output logic [2:0]        border,
	output logic              ear_out,
	output logic              mic_out
);

	import zx_pkg::*;

	// Port write pulses
	logic  wr_7ffd;
	logic  wr_1ffd;
	logic  wr_eff7;
	logic  wr_dffd;
	logic  wr_ula;
	byte_t wr_data;

	// Paging state
	ram_page_t  page_ram;
	rom_page_t  page_rom;
	logic       special_mode;
	logic [1:0] special_sel;
	logic       plus3;

	bus_cycle_decode i_bus_cycle_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.plus3    (plus3),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_eff7  (wr_eff7),
		.wr_dffd  (wr_dffd),
		.wr_ula   (wr_ula),
		.wr_data  (wr_data)
	);

	page_registers i_page_registers (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.wr_7ffd      (wr_7ffd),
		.wr_1ffd      (wr_1ffd),
		.wr_eff7      (wr_eff7),
		.wr_dffd      (wr_dffd),
		.wr_data      (wr_data),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.special_mode (special_mode),
		.special_sel  (special_sel),
		.plus3        (plus3)
	);

	memory_map i_memory_map (
		.mreq_n       (mreq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.addr         (addr),
		.page_ram     (page_ram),
		.page_rom     (page_rom),
		.special_mode (special_mode),
		.special_sel  (special_sel),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.ram_rd       (ram_rd)
	);

	io_ports i_io_ports (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.m1_n     (m1_n),
		.wr_ula   (wr_ula),
		.wr_data  (wr_data),
		.joy_mode (joy_mode),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.key_data (key_data),
		.tape_in  (tape_in),
		.cpu_din  (cpu_din),
		.border   (border),
		.ear_out  (ear_out),
		.mic_out  (mic_out)
	);

endmodule

`default_nettype wire

//--- sim/zx_memory_io_checker.sv
// Bound assertions on the RAM strobes and the ROM write protection
`timescale 1ns/10ps
`default_nettype none

module zx_memory_io_checker (
	input logic              clk_sys,
	input logic              reset,
	input logic              mreq_n,
	input zx_pkg::cpu_addr_t addr,
	input logic              ram_we,
	input logic              ram_rd,
	input logic              special_mode
);

	// Count of failed assertions
	int assert_fails = 0;

	// Strobes only inside a memory cycle
	strobe_needs_mreq : assert property (
		@(posedge clk_sys) disable iff (reset) (ram_we || ram_rd) |-> !mreq_n
	) else begin
		$error("RAM strobe active while mreq_n is high");
		assert_fails++;
	end

	strobes_exclusive : assert property (
		@(posedge clk_sys) disable iff (reset) !(ram_we && ram_rd)
	) else begin
		$error("ram_we and ram_rd active together");
		assert_fails++;
	end

	// ROM slot is read only outside all-RAM mode
	rom_write_blocked : assert property (
		@(posedge clk_sys) disable iff (reset) ram_we |-> (special_mode || addr[15:14] != 2'd0)
	) else begin
		$error("ram_we active in slot 0 outside special mode");
		assert_fails++;
	end

endmodule

bind zx_memory_io zx_memory_io_checker i_checker (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.mreq_n       (mreq_n),
	.addr         (addr),
	.ram_we       (ram_we),
	.ram_rd       (ram_rd),
	.special_mode (special_mode)
);

`default_nettype wire

//--- sim/tb_zx_memory_io.sv
// Directed testbench for the Spectrum memory paging and I/O port core
`timescale 1ns/10ps
`default_nettype none

module tb_zx_memory_io;

	import zx_pkg::*;

	localparam int CLK_PERIOD    = 8;
	localparam int RESET_CYCLES  = 10;
	localparam logic [31:0] LCG_SEED = 32'd66;

	// ==============================
	// Run length
	// ==============================

	// One bus helper is a setup edge, 3 held clocks and 2 idle clocks
	localparam int ACCESS_CLOCKS = 6;
	localparam int RESET_CLOCKS  = RESET_CYCLES + 2;

	// Bus cycles per test as counted from the loops below
	localparam int LEN_RESET_MAP = 6 * (RESET_CLOCKS + 6 * ACCESS_CLOCKS);
	localparam int LEN_7FFD      = 3 * RESET_CLOCKS + 100 * ACCESS_CLOCKS;
	localparam int LEN_PLUS3     = RESET_CLOCKS + 50 * ACCESS_CLOCKS;
	localparam int LEN_EXT       = 2 * RESET_CLOCKS + 50 * ACCESS_CLOCKS;
	localparam int LEN_ULA       = RESET_CLOCKS + 30 * ACCESS_CLOCKS;
	localparam int LEN_JOY       = RESET_CLOCKS + 150 * ACCESS_CLOCKS;
	localparam int TEST_CLOCKS   = RESET_CLOCKS + LEN_RESET_MAP + LEN_7FFD + LEN_PLUS3
		+ LEN_EXT + LEN_ULA + LEN_JOY;
	localparam int WATCHDOG_NS   = (2 * TEST_CLOCKS + 1000) * CLK_PERIOD;

	// DUT inputs
	logic       clk_sys;
	logic       reset;
	cpu_addr_t  addr;
	byte_t      cpu_dout;
	logic       mreq_n;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic       m1_n;
	machine_t   machine;
	joy_mode_t  joy_mode;
	joy_t       joy_0;
	joy_t       joy_1;
	logic [4:0] key_data;
	logic       tape_in;

	// DUT outputs
	ram_addr_t  ram_addr;
	logic       ram_we;
	logic       ram_rd;
	byte_t      cpu_din;
	logic [2:0] border;
	logic       ear_out;
	logic       mic_out;

	int error_count = 0;
	int check_count = 0;
	int tests_run   = 0;

	logic [31:0] lcg_state = LCG_SEED;

	// Reference state of the paging registers and ULA latch
	machine_t   ref_machine;
	logic [2:0] ref_bank;
	logic       ref_rom;
	logic       ref_lock;
	logic [2:0] ref_1ffd;
	logic       ref_eff7;
	logic [2:0] ref_ext;
	logic [2:0] ref_border;
	logic       ref_ear;
	logic       ref_mic;

	zx_memory_io i_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.machine  (machine),
		.joy_mode (joy_mode),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.key_data (key_data),
		.tape_in  (tape_in),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.ram_rd   (ram_rd),
		.cpu_din  (cpu_din),
		.border   (border),
		.ear_out  (ear_out),
		.mic_out  (mic_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic byte_t rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// ==============================
	// Reference model
	// ==============================

	function automatic logic page_lock_active();
		return (ref_machine == MACHINE_48K)
			|| (ref_machine != MACHINE_P1024 && ref_lock)
			|| (ref_machine == MACHINE_P1024 && ref_eff7 && ref_lock);
	endfunction

	function automatic rom_page_t rom_page_now();
		if (ref_machine == MACHINE_48K) begin
			return 4'b1111;
		end else if (ref_machine == MACHINE_PLUS3) begin
			return {2'b10, ref_1ffd[2], ref_rom};
		end
		return {3'b011, ref_rom};
	endfunction

	function automatic ram_page_t layout_page(input logic [1:0] sel, input logic [1:0] slot);
		logic [15:0] layout;
		// Hex digit per slot from slot 3 down to slot 0
		case (sel)
			2'd0: layout = 16'h3210;
			2'd1: layout = 16'h7654;
			2'd2: layout = 16'h3654;
			default: layout = 16'h3674;
		endcase
		return {2'b00, layout[slot * 4 +: 4]};
	endfunction

	function automatic ram_addr_t translate_addr(input cpu_addr_t a);
		ram_page_t page;
		if (ref_1ffd[0]) begin
			page = layout_page(ref_1ffd[2:1], a[15:14]);
		end else begin
			case (a[15:14])
				2'd0: return {ROM_PAGE_BASE, rom_page_now(), a[13:0]};
				2'd1: page = 6'd5;
				2'd2: page = 6'd2;
				default: page = {ref_ext, ref_bank};
			endcase
		end
		return {1'b0, page, a[13:0]};
	endfunction

	function automatic logic write_allowed(input cpu_addr_t a);
		return ref_1ffd[0] || (a[15:14] != 2'd0);
	endfunction

	function automatic logic [4:0] sinclair_i(input joy_t j);
		logic [4:0] keys;
		keys[4] = j[1];
		keys[3] = j[0];
		keys[2] = j[2];
		keys[1] = j[3];
		keys[0] = j[4];
		return keys;
	endfunction

	// Keys 1 to 5 sit on bits 0 to 4
	function automatic logic [4:0] sinclair_ii(input joy_t j);
		logic [4:0] keys;
		keys[0] = j[1];
		keys[1] = j[0];
		keys[2] = j[2];
		keys[3] = j[3];
		keys[4] = j[4];
		return keys;
	endfunction

	// Cursor keys 6 down, 7 up, 8 right, 0 fire
	function automatic logic [4:0] cursor_row(input joy_t j);
		logic [4:0] keys;
		keys[0] = j[4];
		keys[1] = 1'b0;
		keys[2] = j[0];
		keys[3] = j[3];
		keys[4] = j[2];
		return keys;
	endfunction

	function automatic byte_t keyboard_byte(input cpu_addr_t a, input int mode,
		input joy_t j0, input joy_t j1, input logic [4:0] keys, input logic tape);
		logic [4:0] row_60;
		logic [4:0] row_15;
		logic [4:0] pressed;
		row_60 = 5'd0;
		row_15 = 5'd0;
		case (mode)
			1: row_60 = sinclair_i(j0) | sinclair_i(j1);
			2: row_15 = sinclair_ii(j0) | sinclair_ii(j1);
			3: begin
				row_60 = sinclair_i(j0);
				row_15 = sinclair_ii(j1);
			end
			4: begin
				row_60 = cursor_row(j0) | cursor_row(j1);
				// Key 5 is cursor left
				row_15[4] = j0[1] | j1[1];
			end
			default: begin
			end
		endcase
		pressed = 5'd0;
		if (!a[12]) begin
			pressed = pressed | row_60;
		end
		if (!a[11]) begin
			pressed = pressed | row_15;
		end
		return {1'b1, ~tape, 1'b1, keys & ~pressed};
	endfunction

	// ==============================
	// Bus helpers
	// ==============================

	task automatic bus_idle();
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
	endtask

	task automatic finish_cycle();
		repeat (3) @(posedge clk_sys);
		bus_idle();
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic do_reset(input machine_t m);
		@(posedge clk_sys);
		bus_idle();
		machine <= m;
		reset   <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset   <= 1'b0;
		// Latched mode must survive a changed input
		machine <= ~m;
		ref_machine = m;
		ref_bank    = 3'd0;
		ref_rom     = 1'b0;
		ref_lock    = 1'b0;
		ref_1ffd    = 3'd0;
		ref_eff7    = 1'b0;
		ref_ext     = 3'd0;
		ref_border  = 3'd0;
		ref_ear     = 1'b0;
		ref_mic     = 1'b0;
	endtask

	task automatic io_write(input cpu_addr_t a, input byte_t d);
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= d;
		iorq_n   <= 1'b0;
		wr_n     <= 1'b0;
		finish_cycle();
	endtask

	task automatic io_read(input cpu_addr_t a, input byte_t exp, input string what);
		@(posedge clk_sys);
		addr   <= a;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge clk_sys);
		check_count++;
		if (cpu_din !== exp) begin
			$display("[ERROR] %0t ns: %s read of port %h gave %h, expected %h",
				$time, what, a, cpu_din, exp);
			error_count++;
		end
		finish_cycle();
	endtask

	task automatic mem_read(input cpu_addr_t a);
		ram_addr_t exp;
		exp = translate_addr(a);
		@(posedge clk_sys);
		addr   <= a;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge clk_sys);
		check_count++;
		if (ram_rd !== 1'b1 || ram_we !== 1'b0 || ram_addr !== exp) begin
			$display("[ERROR] %0t ns: read of %h gave RAM address %h rd %b we %b, expected %h",
				$time, a, ram_addr, ram_rd, ram_we, exp);
			error_count++;
		end
		finish_cycle();
	endtask

	task automatic mem_write(input cpu_addr_t a);
		logic exp_we;
		exp_we = write_allowed(a);
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= rand_byte();
		mreq_n   <= 1'b0;
		wr_n     <= 1'b0;
		@(negedge clk_sys);
		check_count++;
		if (ram_we !== exp_we || ram_rd !== 1'b0) begin
			$display("[ERROR] %0t ns: write to %h gave ram_we %b ram_rd %b, expected %b and 0",
				$time, a, ram_we, ram_rd, exp_we);
			error_count++;
		end else if (exp_we && ram_addr !== translate_addr(a)) begin
			$display("[ERROR] %0t ns: write to %h gave RAM address %h, expected %h",
				$time, a, ram_addr, translate_addr(a));
			error_count++;
		end
		finish_cycle();
	endtask

	task automatic check_all_slots();
		mem_read(16'h1A5C);
		mem_read(16'h5A5C);
		mem_read(16'h9A5C);
		mem_read(16'hDA5C);
	endtask

	task automatic check_ula();
		check_count++;
		if (border !== ref_border || ear_out !== ref_ear || mic_out !== ref_mic) begin
			$display("[ERROR] %0t ns: border %0d ear %b mic %b, expected %0d %b %b",
				$time, border, ear_out, mic_out, ref_border, ref_ear, ref_mic);
			error_count++;
		end
	endtask

	// Port writes update the model once the bus cycle has ended
	task automatic write_7ffd(input byte_t d);
		logic locked;
		locked = page_lock_active();
		io_write(16'h7FFD, d);
		if (!locked) begin
			ref_bank = d[2:0];
			ref_rom  = d[4];
			ref_lock = d[5];
			if (ref_machine == MACHINE_P1024 && !ref_eff7) begin
				ref_ext = {d[5], d[7:6]};
			end
		end
	endtask

	task automatic write_1ffd(input byte_t d);
		logic locked;
		locked = page_lock_active();
		io_write(16'h1FFD, d);
		if (!locked && ref_machine == MACHINE_PLUS3) begin
			ref_1ffd = d[2:0];
		end
	endtask

	task automatic write_eff7(input byte_t d);
		io_write(16'hEFF7, d);
		if (ref_machine == MACHINE_P1024) begin
			ref_eff7 = d[2];
		end
	endtask

	task automatic write_dffd(input byte_t d);
		io_write(PROFI_PORT, d);
		if (ref_machine == MACHINE_PROFI) begin
			ref_ext = d[2:0];
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		$display("Test %s finished with %0d errors", name, error_count - start_errors);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic test_reset_map();
		int start_errors;
		int m;
		start_errors = error_count;
		// Value 5 is undefined and maps like 128K
		for (m = 0; m < 6; m++) begin
			do_reset(machine_t'(m));
			check_all_slots();
			mem_write(16'h0155);
			mem_write(16'h4155);
			@(negedge clk_sys);
			check_ula();
		end
		report_test("reset and base map", start_errors);
	endtask

	task automatic test_7ffd();
		int start_errors;
		int i;
		start_errors = error_count;
		do_reset(MACHINE_128K);
		for (i = 0; i < 20; i++) begin
			write_7ffd(rand_byte() & 8'hDF);
			mem_read(16'hC3A1);
			mem_read(16'h03A1);
		end
		write_7ffd(rand_byte() | 8'h20);
		check_all_slots();
		for (i = 0; i < 4; i++) begin
			write_7ffd(rand_byte() & 8'hDF);
			mem_read(16'hC3A1);
			mem_read(16'h03A1);
		end
		do_reset(MACHINE_128K);
		write_7ffd(8'h17);
		mem_read(16'hC3A1);
		do_reset(MACHINE_48K);
		for (i = 0; i < 4; i++) begin
			write_7ffd(rand_byte());
			check_all_slots();
		end
		report_test("7FFD paging", start_errors);
	endtask

	task automatic test_plus3();
		int         start_errors;
		int         i;
		logic [1:0] sel;
		start_errors = error_count;
		do_reset(MACHINE_PLUS3);
		for (i = 0; i < 4; i++) begin
			sel = i[1:0];
			write_1ffd({5'b00000, sel, 1'b1});
			check_all_slots();
			mem_write(16'h2468);
		end
		// Normal layout, ROM from 1FFD bit 2 and 7FFD bit 4
		for (i = 0; i < 4; i++) begin
			write_1ffd({5'b00000, i[1], 2'b00});
			write_7ffd({3'b000, i[0], 4'b0011});
			mem_read(16'h0ACE);
			mem_write(16'h0ACE);
			mem_read(16'hCACE);
		end
		write_7ffd(8'h20);
		write_1ffd(8'h01);
		check_all_slots();
		report_test("+3 1FFD", start_errors);
	endtask

	task automatic test_extensions();
		int start_errors;
		int i;
		start_errors = error_count;
		do_reset(MACHINE_P1024);
		for (i = 0; i < 8; i++) begin
			write_7ffd(rand_byte());
			mem_read(16'hE001);
		end
		write_7ffd(rand_byte() & 8'hDF);
		write_eff7(8'h04);
		write_7ffd(rand_byte() & 8'hDF);
		mem_read(16'hE001);
		write_7ffd(rand_byte() | 8'h20);
		write_7ffd(rand_byte());
		mem_read(16'hE001);
		mem_read(16'h0001);
		do_reset(MACHINE_PROFI);
		for (i = 0; i < 8; i++) begin
			write_dffd(rand_byte());
			write_7ffd(rand_byte() & 8'hDF);
			mem_read(16'hE001);
		end
		report_test("paging extensions", start_errors);
	endtask

	task automatic test_ula();
		int    start_errors;
		int    i;
		byte_t d;
		byte_t r;
		start_errors = error_count;
		do_reset(MACHINE_128K);
		for (i = 0; i < 8; i++) begin
			d = rand_byte();
			@(posedge clk_sys);
			addr     <= 16'hFFFE;
			cpu_dout <= d;
			iorq_n   <= 1'b0;
			wr_n     <= 1'b0;
			// First sampling edge only registers the pulse
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_ula();
			ref_border = d[2:0];
			ref_ear    = d[4];
			ref_mic    = d[3];
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_ula();
			@(posedge clk_sys);
			bus_idle();
			repeat (2) @(posedge clk_sys);
		end
		for (i = 0; i < 8; i++) begin
			r = rand_byte();
			@(posedge clk_sys);
			joy_mode <= JOY_KEMPSTON;
			key_data <= r[4:0];
			tape_in  <= r[7];
			io_read(16'hFEFE, keyboard_byte(16'hFEFE, 0, 6'd0, 6'd0, r[4:0], r[7]), "ULA");
		end
		io_read(16'hFFFD, 8'hFF, "unused");
		// Interrupt acknowledge cycles are not port accesses
		@(posedge clk_sys);
		m1_n <= 1'b0;
		io_write(16'hFFFE, ~{3'b000, ref_ear, ref_mic, ref_border});
		@(negedge clk_sys);
		check_ula();
		@(posedge clk_sys);
		m1_n     <= 1'b0;
		key_data <= 5'h00;
		io_read(16'hFEFE, 8'hFF, "M1");
		report_test("ULA port", start_errors);
	endtask

	task automatic test_joysticks();
		int    start_errors;
		int    mode;
		int    i;
		byte_t r0;
		byte_t r1;
		byte_t r2;
		byte_t kempston;
		start_errors = error_count;
		do_reset(MACHINE_128K);
		for (mode = 0; mode < 5; mode++) begin
			for (i = 0; i < 6; i++) begin
				r0 = rand_byte();
				r1 = rand_byte();
				r2 = rand_byte();
				@(posedge clk_sys);
				joy_mode <= joy_mode_t'(mode);
				joy_0    <= r0[5:0];
				joy_1    <= r1[5:0];
				key_data <= r2[4:0];
				tape_in  <= r2[7];
				kempston = (mode == 0) ? {2'b00, r0[5:0] | r1[5:0]} : 8'h00;
				io_read(16'h7F1F, kempston, "Kempston");
				io_read(16'hEFFE,
					keyboard_byte(16'hEFFE, mode, r0[5:0], r1[5:0], r2[4:0], r2[7]), "row 6-0");
				io_read(16'hF7FE,
					keyboard_byte(16'hF7FE, mode, r0[5:0], r1[5:0], r2[4:0], r2[7]), "row 1-5");
				io_read(16'hE7FE,
					keyboard_byte(16'hE7FE, mode, r0[5:0], r1[5:0], r2[4:0], r2[7]), "both rows");
			end
		end
		report_test("joysticks", start_errors);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		reset    = 1'b1;
		addr     = 16'h0000;
		cpu_dout = 8'h00;
		mreq_n   = 1'b1;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		m1_n     = 1'b1;
		machine  = MACHINE_128K;
		joy_mode = JOY_KEMPSTON;
		joy_0    = 6'd0;
		joy_1    = 6'd0;
		key_data = 5'h1F;
		tape_in  = 1'b0;

		do_reset(MACHINE_128K);
		test_reset_map();
		test_7ffd();
		test_plus3();
		test_extensions();
		test_ula();
		test_joysticks();

		error_count += i_dut.i_checker.assert_fails;
		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
			error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- zx_memory_io.f
verilog/zx_pkg.sv
verilog/bus_cycle_decode.sv
verilog/page_registers.sv
verilog/memory_map.sv
verilog/io_ports.sv
verilog/zx_memory_io.sv
sim/zx_memory_io_checker.sv
sim/tb_zx_memory_io.sv
